/* la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;

    localparam int DATA_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;   // r0..r31

    // instruction field positions
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int IMM_LSB = 10;    // si12 sits right above rj
    localparam int IMM_W   = 12;

    // alu operations, no mul/div
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        SLT,    // signed compare
        SLTU    // unsigned compare
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } lsu_op_e;

    // 3R format, matched on inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;

    // 2RI12 format, matched on inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;

endpackage

`default_nettype wire

/* la_bus_pkg.sv */
`default_nettype none

package la_bus_pkg;

    localparam int ADDR_W     = 32;
    localparam int BUS_DATA_W = 32;
    localparam int WORD_BYTES = BUS_DATA_W / 8;   // pc step

    // owner of the shared memory port
    typedef enum logic {
        FETCH,
        LSU
    } req_id_e;

endpackage

`default_nettype wire

/* stage_if.sv */
`default_nettype none

// decode -> execute
interface id_stage_if import la_isa_pkg::*; ();

    logic                  valid;      // one cycle pulse
    logic [DATA_W-1:0]     pc;
    logic [INST_W-1:0]     inst;
    logic [DATA_W-1:0]     oprand1;    // rj
    logic [DATA_W-1:0]     oprand2;    // rk or si12
    alu_op_e               alu_op;
    lsu_op_e               lsu_op;
    logic [DATA_W-1:0]     lsu_data;   // store data, rd
    logic                  rw_en;
    logic [REG_ADDR_W-1:0] rw_addr;

    modport o (output valid, pc, inst, oprand1, oprand2, alu_op, lsu_op, lsu_data,
               rw_en, rw_addr);
    modport i (input valid, pc, inst, oprand1, oprand2, alu_op, lsu_op, lsu_data,
               rw_en, rw_addr);

endinterface

// execute -> lsu
interface ex_stage_if import la_isa_pkg::*; ();

    logic                  valid;
    logic [DATA_W-1:0]     pc;
    logic [DATA_W-1:0]     ex_result;  // alu result, also the memory address
    lsu_op_e               lsu_op;
    logic [DATA_W-1:0]     lsu_data;
    logic                  rw_en;
    logic [REG_ADDR_W-1:0] rw_addr;

    modport o (output valid, pc, ex_result, lsu_op, lsu_data, rw_en, rw_addr);
    modport i (input valid, pc, ex_result, lsu_op, lsu_data, rw_en, rw_addr);

endinterface

`default_nettype wire

/* mem_req_if.sv */
`default_nettype none

// requester <-> arbiter, req and fields held until done
interface mem_req_if import la_bus_pkg::*; ();

    logic                  req;
    logic                  we;
    logic [ADDR_W-1:0]     addr;
    logic [BUS_DATA_W-1:0] wdata;
    logic [BUS_DATA_W-1:0] rdata;    // valid with done
    logic                  done;     // one cycle pulse

    modport requester (output req, we, addr, wdata, input rdata, done);
    modport arbiter (input req, we, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit import la_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    mem_req_if.requester          mem,
    input  logic                  wb_valid,
    output logic                  fetch_valid,
    output logic [ADDR_W-1:0]     fetch_pc,
    output logic [BUS_DATA_W-1:0] fetch_inst
);

    typedef enum logic {
        F_IDLE,     // waiting for retire
        F_BUSY      // request out, waiting for done
    } fetch_state_e;

    fetch_state_e      state;
    logic [ADDR_W-1:0] pc;
    logic              boot;   // first fetch needs no retire to start

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= F_IDLE;
            pc    <= '0;
            boot  <= 1'b1;
        end else begin
            case (state)
                F_IDLE: begin
                    if (boot || wb_valid) begin
                        state <= F_BUSY;
                        boot  <= 1'b0;
                        if (wb_valid)
                            pc <= pc + ADDR_W'(WORD_BYTES);   // next sequential inst
                    end
                end
                F_BUSY: begin
                    if (mem.done)
                        state <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // read-only requester
    assign mem.req   = (state == F_BUSY);
    assign mem.we    = 1'b0;
    assign mem.addr  = pc;
    assign mem.wdata = '0;

    assign fetch_valid = mem.done;    // inst arrives with done
    assign fetch_inst  = mem.rdata;
    assign fetch_pc    = pc;          // pc holds until the next retire

endmodule

`default_nettype wire

/* decode_unit.sv */
`default_nettype none

module decode_unit import la_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_valid,
    input  logic [DATA_W-1:0]     fetch_pc,
    input  logic [INST_W-1:0]     fetch_inst,
    input  logic                  wb_en,
    input  logic [REG_ADDR_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]     wb_data,
    id_stage_if.o                 id_info
);

    logic [DATA_W-1:0]     rf [NUM_REGS];
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [DATA_W-1:0]     imm;
    alu_op_e               alu_op;
    lsu_op_e               lsu_op;
    logic                  use_imm;
    logic                  rw_en;

    assign rd  = fetch_inst[RD_LSB +: REG_ADDR_W];
    assign rj  = fetch_inst[RJ_LSB +: REG_ADDR_W];
    assign rk  = fetch_inst[RK_LSB +: REG_ADDR_W];
    assign imm = {{(DATA_W-IMM_W){fetch_inst[IMM_LSB+IMM_W-1]}},
                  fetch_inst[IMM_LSB +: IMM_W]};    // sign extended si12

    always_comb begin
        alu_op  = ADD;
        lsu_op  = NONE;
        use_imm = 1'b0;
        rw_en   = 1'b1;
        case (fetch_inst[INST_W-1:15])
            OPC_ADD_W: alu_op = ADD;
            OPC_SUB_W: alu_op = SUB;
            OPC_SLT:   alu_op = SLT;
            OPC_SLTU:  alu_op = SLTU;
            OPC_NOR:   alu_op = NOR;
            OPC_AND:   alu_op = AND;
            OPC_OR:    alu_op = OR;
            OPC_XOR:   alu_op = XOR;
            OPC_SLL_W: alu_op = SLL;
            OPC_SRL_W: alu_op = SRL;
            OPC_SRA_W: alu_op = SRA;
            default: begin
                // not 3R, try 2RI12
                use_imm = 1'b1;
                case (fetch_inst[INST_W-1:22])
                    OPC_ADDI_W: alu_op = ADD;
                    OPC_LD_W:   lsu_op = LOAD;     // address = rj + si12
                    OPC_ST_W: begin
                        lsu_op = STORE;
                        rw_en  = 1'b0;             // rd is a source here
                    end
                    default: rw_en = 1'b0;         // unknown, retire as a nop
                endcase
            end
        endcase
    end

    // register file, r0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            rf[wb_addr] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            id_info.valid <= 1'b0;
        else
            id_info.valid <= fetch_valid;
    end

    // payload, held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            id_info.pc       <= fetch_pc;
            id_info.inst     <= fetch_inst;
            id_info.oprand1  <= rf[rj];
            id_info.oprand2  <= use_imm ? imm : rf[rk];
            id_info.alu_op   <= alu_op;
            id_info.lsu_op   <= lsu_op;
            id_info.lsu_data <= rf[rd];
            id_info.rw_en    <= rw_en;
            id_info.rw_addr  <= rd;
        end
    end

endmodule

`default_nettype wire

/* execute.sv */
`default_nettype none

module execute import la_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    id_stage_if.i id_info,
    ex_stage_if.o ex_info
);

    logic [DATA_W-1:0] alu_res;

    alu u_alu (
        .op      (id_info.alu_op),
        .oprand1 (id_info.oprand1),
        .oprand2 (id_info.oprand2),
        .result  (alu_res)
    );

    always_ff @(posedge clk) begin
        if (rst)
            ex_info.valid <= 1'b0;
        else
            ex_info.valid <= id_info.valid;
    end

    // result and side fields stay put until the next instruction
    always_ff @(posedge clk) begin
        if (id_info.valid) begin
            ex_info.pc        <= id_info.pc;
            ex_info.ex_result <= alu_res;
            ex_info.lsu_op    <= id_info.lsu_op;
            ex_info.lsu_data  <= id_info.lsu_data;
            ex_info.rw_en     <= id_info.rw_en;
            ex_info.rw_addr   <= id_info.rw_addr;
        end
    end

endmodule

module alu import la_isa_pkg::*; (
    input  alu_op_e           op,
    input  logic [DATA_W-1:0] oprand1,
    input  logic [DATA_W-1:0] oprand2,
    output logic [DATA_W-1:0] result
);

    logic [4:0] shamt;

    assign shamt = oprand2[4:0];   // shift by low 5 bits only

    always_comb begin
        case (op)
            ADD:  result = oprand1 + oprand2;      // wraps
            SUB:  result = oprand1 - oprand2;
            AND:  result = oprand1 & oprand2;
            OR:   result = oprand1 | oprand2;
            XOR:  result = oprand1 ^ oprand2;
            NOR:  result = ~(oprand1 | oprand2);
            SLL:  result = oprand1 << shamt;
            SRL:  result = oprand1 >> shamt;
            SRA:  result = $signed(oprand1) >>> shamt;
            SLT:  result = {{(DATA_W-1){1'b0}}, $signed(oprand1) < $signed(oprand2)};
            SLTU: result = {{(DATA_W-1){1'b0}}, oprand1 < oprand2};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* lsu.sv */
`default_nettype none

module lsu import la_isa_pkg::*, la_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    ex_stage_if.i                 ex_info,
    mem_req_if.requester          mem,
    output logic                  wb_valid,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output logic [DATA_W-1:0]     wb_data,
    output logic [DATA_W-1:0]     wb_pc
);

    typedef enum logic {
        L_IDLE,
        L_MEM       // memory access in progress
    } lsu_state_e;

    lsu_state_e state;
    logic       arith;

    assign arith = (ex_info.lsu_op == NONE);

    // ex fields are stable while one instruction is in flight
    assign mem.req   = (state == L_MEM);
    assign mem.we    = (ex_info.lsu_op == STORE);
    assign mem.addr  = ex_info.ex_result;
    assign mem.wdata = ex_info.lsu_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= L_IDLE;
            wb_valid <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            wb_valid <= 1'b0;    // pulses
            wb_en    <= 1'b0;
            case (state)
                L_IDLE: begin
                    if (ex_info.valid && arith) begin
                        wb_valid <= 1'b1;
                        wb_en    <= ex_info.rw_en;
                    end else if (ex_info.valid) begin
                        state <= L_MEM;
                    end
                end
                L_MEM: begin
                    if (mem.done) begin
                        wb_valid <= 1'b1;
                        wb_en    <= ex_info.rw_en;    // low for st.w
                        state    <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ex_info.valid && arith)
            wb_data <= ex_info.ex_result;
        else if ((state == L_MEM) && mem.done)
            wb_data <= mem.rdata;    // load data
    end

    assign wb_addr = ex_info.rw_addr;
    assign wb_pc   = ex_info.pc;

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none

module mem_arbiter import la_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    mem_req_if.arbiter            fetch_req,
    mem_req_if.arbiter            lsu_req,
    output logic [ADDR_W-1:0]     paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [BUS_DATA_W-1:0] pwdata,
    input  logic [BUS_DATA_W-1:0] prdata,
    input  logic                  pready
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_SETUP,    // psel only
        A_ACCESS,   // psel + penable until pready
        A_DONE      // done pulse to owner
    } arb_state_e;

    arb_state_e            state;
    req_id_e               owner;
    logic [BUS_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= A_IDLE;
            owner <= FETCH;
        end else begin
            case (state)
                A_IDLE: begin
                    if (lsu_req.req || fetch_req.req) begin
                        owner <= lsu_req.req ? LSU : FETCH;   // lsu wins a tie
                        state <= A_SETUP;
                    end
                end
                A_SETUP:  state <= A_ACCESS;
                A_ACCESS: begin
                    if (pready)
                        state <= A_DONE;
                end
                A_DONE:   state <= A_IDLE;    // requester drops req here
                default:  state <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == A_ACCESS) && pready)
            rdata_q <= prdata;
    end

    assign psel    = (state == A_SETUP) || (state == A_ACCESS);
    assign penable = (state == A_ACCESS);

    // owner holds its fields steady for the whole transfer
    assign paddr  = (owner == LSU) ? lsu_req.addr  : fetch_req.addr;
    assign pwrite = (owner == LSU) ? lsu_req.we    : fetch_req.we;
    assign pwdata = (owner == LSU) ? lsu_req.wdata : fetch_req.wdata;

    assign fetch_req.done  = (state == A_DONE) && (owner == FETCH);
    assign fetch_req.rdata = (owner == FETCH) ? rdata_q : '0;
    assign lsu_req.done    = (state == A_DONE) && (owner == LSU);
    assign lsu_req.rdata   = (owner == LSU) ? rdata_q : '0;

endmodule

`default_nettype wire

/* core_top.sv */
`default_nettype none

module core_top import la_isa_pkg::*, la_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic [ADDR_W-1:0]     paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [BUS_DATA_W-1:0] pwdata,
    input  logic [BUS_DATA_W-1:0] prdata,
    input  logic                  pready,
    output logic                  retire_valid,
    output logic                  retire_en,
    output logic [REG_ADDR_W-1:0] retire_addr,
    output logic [DATA_W-1:0]     retire_data,
    output logic [DATA_W-1:0]     retire_pc
);

    logic                  fetch_valid;
    logic [ADDR_W-1:0]     fetch_pc;
    logic [BUS_DATA_W-1:0] fetch_inst;
    logic                  wb_valid;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic [DATA_W-1:0]     wb_pc;

    mem_req_if  fetch_mem ();
    mem_req_if  lsu_mem ();
    id_stage_if id_bus ();
    ex_stage_if ex_bus ();

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .mem         (fetch_mem),
        .wb_valid    (wb_valid),     // retire starts the next fetch
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode_unit u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .id_info     (id_bus)
    );

    execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .id_info (id_bus),
        .ex_info (ex_bus)
    );

    lsu u_lsu (
        .clk      (clk),
        .rst      (rst),
        .ex_info  (ex_bus),
        .mem      (lsu_mem),
        .wb_valid (wb_valid),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .wb_pc    (wb_pc)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_mem),
        .lsu_req   (lsu_mem),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    // writeback doubles as the retire port
    assign retire_valid = wb_valid;
    assign retire_en    = wb_en;
    assign retire_addr  = wb_addr;
    assign retire_data  = wb_data;
    assign retire_pc    = wb_pc;

endmodule

`default_nettype wire

/* tb_core_top.sv */
`default_nettype none

module tb_core_top import la_isa_pkg::*; ();

    localparam logic [31:0] DMEM_BASE    = 32'h0000_1000;
    localparam int          DMEM_WORDS   = 16;
    localparam int          RESET_CYCLES = 5;
    localparam int          ROW_CYCLES   = 20;    // worst case per inst incl. stalls

    logic        clk;
    logic        rst;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        retire_valid;
    logic        retire_en;
    logic [4:0]  retire_addr;
    logic [31:0] retire_data;
    logic [31:0] retire_pc;

    // stimulus table, one row per instruction at pc = 4*row
    string       row_name [$];
    logic [31:0] row_inst [$];
    logic        row_en   [$];
    logic [4:0]  row_rd   [$];
    logic [31:0] row_val  [$];

    logic [31:0] mirror   [32];           // reference register file
    logic [31:0] ref_dmem [DMEM_WORDS];   // expected data memory
    logic [31:0] dmem     [DMEM_WORDS];   // model data memory
    integer      seed;
    int          wait_left;
    int          errors;
    int          checks;
    int          retired;
    int          cycle_cnt;
    int          cycle_limit;

    core_top UUT (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .retire_valid (retire_valid),
        .retire_en    (retire_en),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data),
        .retire_pc    (retire_pc)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return addr ^ 32'ha5a5_5a5a;     // every address bit shows up
    endfunction

    function automatic logic in_dmem(logic [31:0] addr);
        return (addr >= DMEM_BASE) && (addr < DMEM_BASE + 4 * DMEM_WORDS);
    endfunction

    function automatic int dmem_index(logic [31:0] addr);
        return int'((addr - DMEM_BASE) >> 2);
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // expected result straight from the ALU rules
    function automatic logic [31:0] ref_alu(logic [16:0] opc, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (opc)
            OPC_ADD_W: r = a + b;                  // mod 2^32
            OPC_SUB_W: r = a - b;
            OPC_AND:   r = a & b;
            OPC_OR:    r = a | b;
            OPC_XOR:   r = a ^ b;
            OPC_NOR:   r = ~(a | b);
            OPC_SLL_W: r = a << b[4:0];            // low 5 bits only
            OPC_SRL_W: r = a >> b[4:0];
            OPC_SRA_W: r = $signed(a) >>> b[4:0];
            OPC_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OPC_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
            default:   r = '0;
        endcase
        return r;
    endfunction

    task automatic append_row(string name, logic [31:0] inst, logic en, logic [4:0] rd,
                              logic [31:0] val);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_en.push_back(en);
        row_rd.push_back(rd);
        row_val.push_back(val);
    endtask

    task automatic rr_op(string name, logic [16:0] opc, logic [4:0] rd, logic [4:0] rj,
                         logic [4:0] rk);
        logic [31:0] v;
        v = ref_alu(opc, mirror[rj], mirror[rk]);
        append_row(name, {opc, rk, rj, rd}, 1'b1, rd, v);
        if (rd != 0)
            mirror[rd] = v;    // r0 stays zero
    endtask

    task automatic addi_op(string name, logic [4:0] rd, logic [4:0] rj, logic [11:0] imm);
        logic [31:0] v;
        v = mirror[rj] + sext12(imm);
        append_row(name, {OPC_ADDI_W, imm, rj, rd}, 1'b1, rd, v);
        if (rd != 0)
            mirror[rd] = v;
    endtask

    task automatic load_op(string name, logic [4:0] rd, logic [4:0] rj, logic [11:0] imm);
        logic [31:0] v;
        v = ref_dmem[dmem_index(mirror[rj] + sext12(imm))];
        append_row(name, {OPC_LD_W, imm, rj, rd}, 1'b1, rd, v);
        if (rd != 0)
            mirror[rd] = v;
    endtask

    task automatic store_op(string name, logic [4:0] rd, logic [4:0] rj, logic [11:0] imm);
        ref_dmem[dmem_index(mirror[rj] + sext12(imm))] = mirror[rd];    // rd is the data
        append_row(name, {OPC_ST_W, imm, rj, rd}, 1'b0, rd, '0);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    // apb slave, random wait states before pready
    always @(posedge clk) begin
        #1;
        if (rst) begin
            pready = 1'b0;
        end else if (psel && !penable) begin
            wait_left = $unsigned($random(seed)) % 4;    // setup phase
            pready    = 1'b0;
        end else if (psel && penable) begin
            if (wait_left == 0) begin
                pready = 1'b1;
                if (pwrite && in_dmem(paddr))
                    dmem[dmem_index(paddr)] = pwdata;
                else if (in_dmem(paddr))
                    prdata = dmem[dmem_index(paddr)];
                else if ((paddr >> 2) < row_inst.size())
                    prdata = row_inst[paddr >> 2];
                else
                    prdata = '0;    // past the table, decodes as a nop
            end else begin
                wait_left--;
            end
        end else begin
            pready = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: core stopped retiring, %0d of %0d rows retired in %0d cycles",
                     retired, row_inst.size(), cycle_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        clk       = 1'b0;
        rst       = 1'b1;
        pready    = 1'b0;
        prdata    = '0;
        seed      = 32'h5dd4_f403;
        wait_left = 0;
        errors    = 0;
        checks    = 0;
        retired   = 0;
        cycle_cnt = 0;
        for (int r = 0; r < 32; r++)
            mirror[r] = '0;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            dmem[w]     = fill_word(DMEM_BASE + 4 * w);
            ref_dmem[w] = fill_word(DMEM_BASE + 4 * w);
        end

        // random immediates, both signs
        rnd = $random(seed);
        addi_op("addi_pos_rand", 1, 0, {1'b0, rnd[10:0]});
        rnd = $random(seed);
        addi_op("addi_neg_rand", 2, 0, {1'b1, rnd[10:0]});
        rnd = $random(seed);
        addi_op("addi_rand", 3, 0, rnd[11:0]);
        rnd = $random(seed);
        addi_op("addi_chain_neg", 4, 1, {1'b1, rnd[10:0]});
        rr_op("and", OPC_AND, 5, 1, 2);
        rr_op("or", OPC_OR, 6, 1, 2);
        rr_op("xor", OPC_XOR, 7, 2, 3);
        rr_op("nor", OPC_NOR, 8, 3, 4);
        rr_op("add_w", OPC_ADD_W, 9, 1, 2);
        rr_op("sub_w", OPC_SUB_W, 10, 2, 1);
        addi_op("addi_one", 11, 0, 12'd1);
        addi_op("addi_31", 12, 0, 12'd31);
        rr_op("sll_top_bit", OPC_SLL_W, 13, 11, 12);    // 0x8000_0000
        rr_op("add_wrap", OPC_ADD_W, 14, 13, 13);
        rr_op("sub_wrap", OPC_SUB_W, 15, 0, 11);        // all ones
        addi_op("addi_35", 16, 0, 12'd35);
        rr_op("srl_by_35", OPC_SRL_W, 17, 15, 16);
        rr_op("sra_by_35", OPC_SRA_W, 18, 13, 16);
        rr_op("sll_by_35", OPC_SLL_W, 19, 15, 16);
        rr_op("srl_rand", OPC_SRL_W, 20, 2, 3);
        // top bit set, signed and unsigned disagree
        rr_op("slt_neg_pos", OPC_SLT, 21, 13, 11);
        rr_op("sltu_neg_pos", OPC_SLTU, 22, 13, 11);
        rr_op("slt_pos_neg", OPC_SLT, 23, 11, 13);
        rr_op("sltu_pos_neg", OPC_SLTU, 24, 11, 13);
        addi_op("addi_12", 25, 0, 12'd12);
        rr_op("sll_base", OPC_SLL_W, 26, 11, 25);       // 0x1000
        store_op("st_rand", 2, 26, 12'd8);
        store_op("st_ones", 15, 26, 12'd12);
        load_op("ld_rand", 27, 26, 12'd8);
        load_op("ld_ones", 28, 26, 12'd12);
        load_op("ld_fill", 29, 26, 12'd20);             // untouched word
        addi_op("addi_r0", 0, 0, 12'd5);                // retires, r0 stays 0
        rr_op("add_read_r0", OPC_ADD_W, 30, 0, 1);
        rr_op("or_r0_r0", OPC_OR, 31, 0, 0);

        cycle_limit = row_inst.size() * ROW_CYCLES + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;

        // retire port is registered, read it mid cycle
        for (int i = 0; i < row_inst.size(); i++) begin
            do
                @(negedge clk);
            while (!retire_valid);
            retired++;
            check_value($sformatf("%s pc", row_name[i]), 4 * i, retire_pc);
            check_value($sformatf("%s en", row_name[i]), row_en[i], retire_en);
            if (row_en[i]) begin
                check_value($sformatf("%s rd", row_name[i]), row_rd[i], retire_addr);
                check_value($sformatf("%s value", row_name[i]), row_val[i], retire_data);
            end
        end
        for (int w = 0; w < DMEM_WORDS; w++)
            check_value($sformatf("dmem word %0d", w), ref_dmem[w], dmem[w]);

        $display("retired %0d rows, %0d checks, %0d errors", retired, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
la_isa_pkg.sv
la_bus_pkg.sv
stage_if.sv
mem_req_if.sv
fetch_unit.sv
decode_unit.sv
execute.sv
lsu.sv
mem_arbiter.sv
core_top.sv
tb_core_top.sv

/* Bender.yml */
package:
  name: la32_core

sources:
  - la_isa_pkg.sv
  - la_bus_pkg.sv
  - stage_if.sv
  - mem_req_if.sv
  - fetch_unit.sv
  - decode_unit.sv
  - execute.sv
  - lsu.sv
  - mem_arbiter.sv
  - core_top.sv
  - target: test
    files:
      - tb_core_top.sv
